/* Makefile */
SIM = obj_dir/exec_sim
LOG = sim.log

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): compile.f hdl/exec_consts.svh hdl/*.sv test/*.sv
	verilator --binary --assert -Wno-fatal -f compile.f --top-module exec_tb \
		-Mdir obj_dir -o exec_sim

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* compile.f */
+incdir+hdl
hdl/exec_pkg.sv
hdl/reg_file.sv
hdl/instr_decode.sv
hdl/serial_divider.sv
hdl/execute_stage.sv
hdl/exec_top.sv
test/exec_sva.sv
test/exec_tb.sv

/* hdl/exec_consts.svh */
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// Data path width
`define EXEC_XLEN 32

// Architectural register count and the address width derived from it
`define EXEC_NREGS 32
`define EXEC_RAW ($clog2(`EXEC_NREGS))

// One restoring step per quotient bit
`define EXEC_DIV_STEPS `EXEC_XLEN

// Major opcodes of the supported groups
`define EXEC_OPC_OP 7'b0110011
`define EXEC_OPC_IMM 7'b0010011

`endif

/* hdl/exec_pkg.sv */
package exec_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Operation codes carried from decode to execute
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    op_add,
    op_sub,
    op_sll,
    op_slt,
    op_sltu,
    op_xor,
    op_srl,
    op_sra,
    op_or,
    op_and,
    op_divu,
    op_remu,
    op_nop
  } alu_op_t;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction word formats
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_format_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_format_t;

  // Same 32 bits, register-register or immediate view
  typedef union packed {
    r_format_t rtype;
    i_format_t itype;
  } instr_u;

endpackage

/* hdl/exec_top.sv */
`timescale 1ns/1ps

`include "exec_consts.svh"

module exec_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid,
  input  logic [31:0]           instr,
  output logic                  busy,
  output logic                  wb_valid,
  output logic [`EXEC_RAW-1:0]  wb_addr,
  output logic [`EXEC_XLEN-1:0] wb_data
);

  import exec_pkg::*;

  logic [`EXEC_RAW-1:0]  rs1_addr;
  logic [`EXEC_RAW-1:0]  rs2_addr;
  logic [`EXEC_XLEN-1:0] rs1_data;
  logic [`EXEC_XLEN-1:0] rs2_data;

  logic                  ex_valid;
  alu_op_t               ex_op;
  logic [`EXEC_RAW-1:0]  ex_rd;
  logic [`EXEC_XLEN-1:0] ex_a;
  logic [`EXEC_XLEN-1:0] ex_b;
  logic                  ex_stall;

  logic                  fwd_valid;
  logic [`EXEC_RAW-1:0]  fwd_addr;
  logic [`EXEC_XLEN-1:0] fwd_data;

  logic                  div_start;
  logic [`EXEC_XLEN-1:0] div_dividend;
  logic [`EXEC_XLEN-1:0] div_divisor;
  logic                  div_ready;
  logic [`EXEC_XLEN-1:0] div_quotient;
  logic [`EXEC_XLEN-1:0] div_remainder;

  instr_decode u_decode (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .instr     (instr),
    .rs1_addr  (rs1_addr),
    .rs2_addr  (rs2_addr),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .fwd_valid (fwd_valid),
    .fwd_addr  (fwd_addr),
    .fwd_data  (fwd_data),
    .stall     (ex_stall),
    .ex_valid  (ex_valid),
    .ex_op     (ex_op),
    .ex_rd     (ex_rd),
    .ex_a      (ex_a),
    .ex_b      (ex_b)
  );

  // Write port is fed by the writeback register
  reg_file u_regs (
    .clk    (clk),
    .rst    (rst),
    .raddr1 (rs1_addr),
    .raddr2 (rs2_addr),
    .rdata1 (rs1_data),
    .rdata2 (rs2_data),
    .wren   (wb_valid),
    .waddr  (wb_addr),
    .wdata  (wb_data)
  );

  execute_stage u_execute (
    .clk           (clk),
    .rst           (rst),
    .ex_valid      (ex_valid),
    .ex_op         (ex_op),
    .ex_rd         (ex_rd),
    .ex_a          (ex_a),
    .ex_b          (ex_b),
    .stall         (ex_stall),
    .fwd_valid     (fwd_valid),
    .fwd_addr      (fwd_addr),
    .fwd_data      (fwd_data),
    .div_start     (div_start),
    .div_dividend  (div_dividend),
    .div_divisor   (div_divisor),
    .div_ready     (div_ready),
    .div_quotient  (div_quotient),
    .div_remainder (div_remainder),
    .busy          (busy),
    .wb_valid      (wb_valid),
    .wb_addr       (wb_addr),
    .wb_data       (wb_data)
  );

  serial_divider u_divider (
    .clk           (clk),
    .rst           (rst),
    .div_start     (div_start),
    .div_dividend  (div_dividend),
    .div_divisor   (div_divisor),
    .div_ready     (div_ready),
    .div_quotient  (div_quotient),
    .div_remainder (div_remainder)
  );

endmodule

/* hdl/execute_stage.sv */
`timescale 1ns/1ps

`include "exec_consts.svh"

module execute_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  ex_valid,
  input  exec_pkg::alu_op_t     ex_op,
  input  logic [`EXEC_RAW-1:0]  ex_rd,
  input  logic [`EXEC_XLEN-1:0] ex_a,
  input  logic [`EXEC_XLEN-1:0] ex_b,
  output logic                  stall,
  output logic                  fwd_valid,
  output logic [`EXEC_RAW-1:0]  fwd_addr,
  output logic [`EXEC_XLEN-1:0] fwd_data,
  output logic                  div_start,
  output logic [`EXEC_XLEN-1:0] div_dividend,
  output logic [`EXEC_XLEN-1:0] div_divisor,
  input  logic                  div_ready,
  input  logic [`EXEC_XLEN-1:0] div_quotient,
  input  logic [`EXEC_XLEN-1:0] div_remainder,
  output logic                  busy,
  output logic                  wb_valid,
  output logic [`EXEC_RAW-1:0]  wb_addr,
  output logic [`EXEC_XLEN-1:0] wb_data
);

  import exec_pkg::*;

  localparam int SHW = $clog2(`EXEC_XLEN);

  logic                  is_div;
  logic                  div_pending;
  logic                  wr_en;
  logic [SHW-1:0]        shamt;
  logic [`EXEC_XLEN-1:0] alu_res;
  logic [`EXEC_XLEN-1:0] result;

  assign shamt = ex_b[SHW-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (ex_op)
      op_add:  alu_res = ex_a + ex_b;
      op_sub:  alu_res = ex_a - ex_b;
      op_sll:  alu_res = ex_a << shamt;
      op_slt:  alu_res = {{(`EXEC_XLEN-1){1'b0}}, $signed(ex_a) < $signed(ex_b)};
      op_sltu: alu_res = {{(`EXEC_XLEN-1){1'b0}}, ex_a < ex_b};
      op_xor:  alu_res = ex_a ^ ex_b;
      op_srl:  alu_res = ex_a >> shamt;
      op_sra:  alu_res = $signed(ex_a) >>> shamt;
      op_or:   alu_res = ex_a | ex_b;
      op_and:  alu_res = ex_a & ex_b;
      default: alu_res = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Divider control and stall
  ////////////////////////////////////////////////////////////////////////////

  assign is_div = (ex_op == op_divu) || (ex_op == op_remu);

  // One start per divide, the pending flag blocks a restart while it runs
  assign div_start    = ex_valid && is_div && !div_pending;
  assign div_dividend = ex_a;
  assign div_divisor  = ex_b;

  always_ff @(posedge clk) begin
    if (!rst) begin
      div_pending <= 1'b0;
    end else if (div_ready) begin
      div_pending <= 1'b0;
    end else if (div_start) begin
      div_pending <= 1'b1;
    end
  end

  assign stall = ex_valid && is_div && !div_ready;
  assign busy  = ex_valid && is_div;

  always_comb begin
    if (ex_op == op_divu) begin
      result = div_quotient;
    end else if (ex_op == op_remu) begin
      result = div_remainder;
    end else begin
      result = alu_res;
    end
  end

  // No-ops and x0 targets never reach writeback
  assign wr_en = ex_valid && !stall && ex_op != op_nop && ex_rd != '0;

  assign fwd_valid = wr_en;
  assign fwd_addr  = ex_rd;
  assign fwd_data  = result;

  ////////////////////////////////////////////////////////////////////////////
  // Writeback register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= wr_en;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      wb_addr <= ex_rd;
      wb_data <= result;
    end
  end

endmodule

/* hdl/instr_decode.sv */
`timescale 1ns/1ps

`include "exec_consts.svh"

module instr_decode (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid,
  input  exec_pkg::instr_u      instr,
  output logic [`EXEC_RAW-1:0]  rs1_addr,
  output logic [`EXEC_RAW-1:0]  rs2_addr,
  input  logic [`EXEC_XLEN-1:0] rs1_data,
  input  logic [`EXEC_XLEN-1:0] rs2_data,
  input  logic                  fwd_valid,
  input  logic [`EXEC_RAW-1:0]  fwd_addr,
  input  logic [`EXEC_XLEN-1:0] fwd_data,
  input  logic                  stall,
  output logic                  ex_valid,
  output exec_pkg::alu_op_t     ex_op,
  output logic [`EXEC_RAW-1:0]  ex_rd,
  output logic [`EXEC_XLEN-1:0] ex_a,
  output logic [`EXEC_XLEN-1:0] ex_b
);

  import exec_pkg::*;

  alu_op_t               dec_op;
  logic [`EXEC_XLEN-1:0] dec_b;
  logic [`EXEC_XLEN-1:0] imm_ext;
  logic [`EXEC_XLEN-1:0] rs1_val;
  logic [`EXEC_XLEN-1:0] rs2_val;

  assign rs1_addr = instr.rtype.rs1;
  assign rs2_addr = instr.rtype.rs2;

  assign imm_ext = {{(`EXEC_XLEN-12){instr.itype.imm[11]}}, instr.itype.imm};

  // Result still sitting in execute wins over the register file
  assign rs1_val = (fwd_valid && fwd_addr == rs1_addr && rs1_addr != '0) ? fwd_data : rs1_data;
  assign rs2_val = (fwd_valid && fwd_addr == rs2_addr && rs2_addr != '0) ? fwd_data : rs2_data;

  ////////////////////////////////////////////////////////////////////////////
  // Opcode and function decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    dec_op = op_nop;
    dec_b  = rs2_val;
    case (instr.rtype.opcode)
      `EXEC_OPC_OP: begin
        case (instr.rtype.funct7)
          7'b0000000: begin
            case (instr.rtype.funct3)
              3'd0: dec_op = op_add;
              3'd1: dec_op = op_sll;
              3'd2: dec_op = op_slt;
              3'd3: dec_op = op_sltu;
              3'd4: dec_op = op_xor;
              3'd5: dec_op = op_srl;
              3'd6: dec_op = op_or;
              default: dec_op = op_and;
            endcase
          end
          7'b0100000: begin
            if (instr.rtype.funct3 == 3'd0) begin
              dec_op = op_sub;
            end else if (instr.rtype.funct3 == 3'd5) begin
              dec_op = op_sra;
            end
          end
          7'b0000001: begin
            if (instr.rtype.funct3 == 3'd5) begin
              dec_op = op_divu;
            end else if (instr.rtype.funct3 == 3'd7) begin
              dec_op = op_remu;
            end
          end
          default: ;
        endcase
      end
      `EXEC_OPC_IMM: begin
        dec_b = imm_ext;
        case (instr.itype.funct3)
          3'd0: dec_op = op_add;
          3'd2: dec_op = op_slt;
          3'd3: dec_op = op_sltu;
          3'd4: dec_op = op_xor;
          3'd6: dec_op = op_or;
          3'd7: dec_op = op_and;
          3'd1: begin
            if (instr.itype.imm[11:5] == 7'b0000000) dec_op = op_sll;
          end
          default: begin
            // funct3 5, upper immediate bits select the shift kind
            if (instr.itype.imm[11:5] == 7'b0000000) begin
              dec_op = op_srl;
            end else if (instr.itype.imm[11:5] == 7'b0100000) begin
              dec_op = op_sra;
            end
          end
        endcase
      end
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Execute stage register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst) begin
      ex_valid <= 1'b0;
    end else if (!stall) begin
      ex_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      ex_op <= dec_op;
      ex_rd <= instr.rtype.rd;
      ex_a  <= rs1_val;
      ex_b  <= dec_b;
    end
  end

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/1ps

`include "exec_consts.svh"

module reg_file (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`EXEC_RAW-1:0]  raddr1,
  input  logic [`EXEC_RAW-1:0]  raddr2,
  output logic [`EXEC_XLEN-1:0] rdata1,
  output logic [`EXEC_XLEN-1:0] rdata2,
  input  logic                  wren,
  input  logic [`EXEC_RAW-1:0]  waddr,
  input  logic [`EXEC_XLEN-1:0] wdata
);

  logic [`EXEC_XLEN-1:0] regs [`EXEC_NREGS];

  // x0 is never written, so it keeps its reset value
  always_ff @(posedge clk) begin
    if (!rst) begin
      for (int k = 0; k < `EXEC_NREGS; k++) begin
        regs[k] <= '0;
      end
    end else if (wren && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // Write-through so a reader in the writeback cycle sees the new value
  always_comb begin
    if (raddr1 == '0) begin
      rdata1 = '0;
    end else if (wren && waddr == raddr1) begin
      rdata1 = wdata;
    end else begin
      rdata1 = regs[raddr1];
    end

    if (raddr2 == '0) begin
      rdata2 = '0;
    end else if (wren && waddr == raddr2) begin
      rdata2 = wdata;
    end else begin
      rdata2 = regs[raddr2];
    end
  end

endmodule

/* hdl/serial_divider.sv */
`timescale 1ns/1ps

`include "exec_consts.svh"

module serial_divider (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  div_start,
  input  logic [`EXEC_XLEN-1:0] div_dividend,
  input  logic [`EXEC_XLEN-1:0] div_divisor,
  output logic                  div_ready,
  output logic [`EXEC_XLEN-1:0] div_quotient,
  output logic [`EXEC_XLEN-1:0] div_remainder
);

  localparam int CW = $clog2(`EXEC_DIV_STEPS + 1);

  logic [CW-1:0]         count;
  logic                  active;
  logic [`EXEC_XLEN-1:0] rem_q;
  logic [`EXEC_XLEN-1:0] quo_q;
  logic [`EXEC_XLEN-1:0] dvs_q;
  logic [`EXEC_XLEN:0]   trial;
  logic [`EXEC_XLEN+1:0] diff;

  // Partial remainder with the next dividend bit shifted in
  assign trial = {rem_q, quo_q[`EXEC_XLEN-1]};
  assign diff  = {1'b0, trial} - {2'b00, dvs_q};

  always_ff @(posedge clk) begin
    if (!rst) begin
      active    <= 1'b0;
      count     <= '0;
      div_ready <= 1'b0;
    end else begin
      div_ready <= 1'b0;
      if (div_start) begin
        active <= 1'b1;
        count  <= CW'(`EXEC_DIV_STEPS);
      end else if (active) begin
        count <= count - 1'b1;
        if (count == CW'(1)) begin
          active    <= 1'b0;
          div_ready <= 1'b1;
        end
      end
    end
  end

  // Restoring step, quotient bits enter at the bottom as dividend bits leave
  // A zero divisor never borrows, which leaves all ones and the dividend
  always_ff @(posedge clk) begin
    if (div_start) begin
      rem_q <= '0;
      quo_q <= div_dividend;
      dvs_q <= div_divisor;
    end else if (active) begin
      if (!diff[`EXEC_XLEN+1]) begin
        rem_q <= diff[`EXEC_XLEN-1:0];
      end else begin
        rem_q <= trial[`EXEC_XLEN-1:0];
      end
      quo_q <= {quo_q[`EXEC_XLEN-2:0], ~diff[`EXEC_XLEN+1]};
    end
  end

  assign div_quotient  = quo_q;
  assign div_remainder = rem_q;

endmodule

/* test/exec_sva.sv */
`timescale 1ns/1ps

`include "exec_consts.svh"

module exec_sva (
  input logic                 clk,
  input logic                 rst,
  input logic                 in_valid,
  input logic                 busy,
  input logic                 wb_valid,
  input logic [`EXEC_RAW-1:0] wb_addr
);

  ////////////////////////////////////////////////////////////////////////////
  // Strobe and stall rules
  ////////////////////////////////////////////////////////////////////////////

  // Source holds off while a divide is in flight
  a_no_strobe_busy: assert property (@(posedge clk) disable iff (!rst) busy |-> !in_valid)
    else $error("in_valid strobed while busy is high");

  // busy only follows an accepted strobe
  a_busy_after_strobe: assert property (@(posedge clk) disable iff (!rst)
    $rose(busy) |-> $past(in_valid))
    else $error("busy rose without a strobe in the previous cycle");

  ////////////////////////////////////////////////////////////////////////////
  // Writeback rules
  ////////////////////////////////////////////////////////////////////////////

  a_wb_in_reset: assert property (@(posedge clk) !rst |=> !wb_valid)
    else $error("wb_valid high during reset");

  a_busy_in_reset: assert property (@(posedge clk) !rst |=> !busy)
    else $error("busy high during reset");

  // x0 targets are dropped before the writeback register
  a_wb_not_x0: assert property (@(posedge clk) disable iff (!rst) wb_valid |-> wb_addr != '0)
    else $error("writeback addressed to x0");

endmodule

/* test/exec_tb.sv */
`timescale 1ns/1ps

`include "exec_consts.svh"

module exec_tb;

  import exec_pkg::*;

  localparam int PERIOD  = 8;
  localparam int N_RAND  = 400;
  localparam int N_INSTR = (`EXEC_NREGS - 1) + 7 + N_RAND;

  logic                  clk;
  logic                  rst;
  logic                  in_valid;
  logic [31:0]           instr;
  logic                  busy;
  logic                  wb_valid;
  logic [`EXEC_RAW-1:0]  wb_addr;
  logic [`EXEC_XLEN-1:0] wb_data;

  integer seed;
  int     cycle = 0;
  int     addr_errors = 0;
  int     data_errors = 0;
  int     ctrl_errors = 0;

  logic [`EXEC_XLEN-1:0] model_regs [`EXEC_NREGS];

  // Expected writebacks in issue order
  logic [`EXEC_RAW-1:0]  exp_addr [$];
  logic [`EXEC_XLEN-1:0] exp_data [$];
  int                    exp_cycle [$];
  bit                    exp_div [$];

  // Divide currently in flight
  bit div_open = 0;
  bit div_writes = 0;
  int div_cycle = 0;

  exec_top dut0 (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .instr    (instr),
    .busy     (busy),
    .wb_valid (wb_valid),
    .wb_addr  (wb_addr),
    .wb_data  (wb_data)
  );

  bind exec_top exec_sva sva0 (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .busy     (busy),
    .wb_valid (wb_valid),
    .wb_addr  (wb_addr)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and instruction encoding
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [`EXEC_XLEN-1:0] ref_result(alu_op_t op, logic [`EXEC_XLEN-1:0] a,
                                                       logic [`EXEC_XLEN-1:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
      op_add:  return a + b;
      op_sub:  return a - b;
      op_sll:  return a << sh;
      op_slt:  return ($signed(a) < $signed(b)) ? 1 : 0;
      op_sltu: return (a < b) ? 1 : 0;
      op_xor:  return a ^ b;
      op_srl:  return a >> sh;
      op_sra:  return $signed(a) >>> sh;
      op_or:   return a | b;
      op_and:  return a & b;
      op_divu: return (b == 0) ? '1 : a / b;
      op_remu: return (b == 0) ? a : a % b;
      default: return '0;
    endcase
  endfunction

  // RV32 funct3 field of each operation
  function automatic logic [2:0] funct3_of(alu_op_t op);
    case (op)
      op_add, op_sub:          return 3'd0;
      op_sll:                  return 3'd1;
      op_slt:                  return 3'd2;
      op_sltu:                 return 3'd3;
      op_xor:                  return 3'd4;
      op_srl, op_sra, op_divu: return 3'd5;
      op_or:                   return 3'd6;
      default:                 return 3'd7;
    endcase
  endfunction

  function automatic instr_u make_r(alu_op_t op, logic [4:0] rd, logic [4:0] rs1,
                                    logic [4:0] rs2);
    instr_u w;
    w.rtype.opcode = `EXEC_OPC_OP;
    w.rtype.rd     = rd;
    w.rtype.rs1    = rs1;
    w.rtype.rs2    = rs2;
    w.rtype.funct3 = funct3_of(op);
    if (op == op_sub || op == op_sra) begin
      w.rtype.funct7 = 7'h20;
    end else if (op == op_divu || op == op_remu) begin
      w.rtype.funct7 = 7'h01;
    end else begin
      w.rtype.funct7 = 7'h00;
    end
    return w;
  endfunction

  function automatic instr_u make_i(alu_op_t op, logic [4:0] rd, logic [4:0] rs1,
                                    logic [11:0] imm);
    instr_u w;
    w.itype.opcode = `EXEC_OPC_IMM;
    w.itype.rd     = rd;
    w.itype.rs1    = rs1;
    w.itype.funct3 = funct3_of(op);
    w.itype.imm    = imm;
    // Shift immediates carry the shift kind in the upper bits
    if (op == op_sll || op == op_srl) w.itype.imm[11:5] = 7'h00;
    if (op == op_sra) w.itype.imm[11:5] = 7'h20;
    return w;
  endfunction

  function automatic int urand(int n);
    return {$random(seed)} % n;
  endfunction

  // Small register set most of the time so that results feed later operands
  function automatic logic [4:0] pick_reg();
    if (urand(4) == 0) return 5'(urand(32));
    return 5'(urand(6));
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic issue(input instr_u w, input alu_op_t op, input bit is_imm);
    logic [`EXEC_XLEN-1:0] a;
    logic [`EXEC_XLEN-1:0] b;
    logic [`EXEC_XLEN-1:0] res;
    bit                    is_div;
    while (busy) begin
      @(posedge clk);
      #1;
    end
    is_div = (op == op_divu) || (op == op_remu);
    a = model_regs[w.rtype.rs1];
    if (is_imm) begin
      b = {{(`EXEC_XLEN-12){w.itype.imm[11]}}, w.itype.imm};
    end else begin
      b = model_regs[w.rtype.rs2];
    end
    res = ref_result(op, a, b);
    if (op != op_nop && w.rtype.rd != 0) begin
      model_regs[w.rtype.rd] = res;
      exp_addr.push_back(w.rtype.rd);
      exp_data.push_back(res);
      exp_cycle.push_back(cycle);
      exp_div.push_back(is_div);
    end
    if (is_div) begin
      div_open   = 1'b1;
      div_writes = (w.rtype.rd != 0);
      div_cycle  = cycle;
    end
    in_valid = 1'b1;
    instr    = w;
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic random_instr();
    int          kind;
    int          f;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    alu_op_t     op;
    instr_u      w;
    kind = urand(100);
    rd   = pick_reg();
    rs1  = pick_reg();
    rs2  = pick_reg();
    imm  = 12'($random(seed));
    if (kind < 40) begin
      op = alu_op_t'(urand(10));
      issue(make_r(op, rd, rs1, rs2), op, 1'b0);
    end else if (kind < 75) begin
      op = alu_op_t'(urand(10));
      if (op == op_sub) op = op_add;
      issue(make_i(op, rd, rs1, imm), op, 1'b1);
    end else if (kind < 88) begin
      op = (urand(2) == 0) ? op_divu : op_remu;
      issue(make_r(op, rd, rs1, rs2), op, 1'b0);
    end else begin
      w = $random(seed);
      case (urand(3))
        0: begin
          // Bit 6 clear in both supported opcodes
          w.rtype.opcode[6] = 1'b1;
        end
        1: begin
          w.rtype.opcode = `EXEC_OPC_OP;
          w.rtype.funct7 = 7'h01;
          f = urand(6);
          w.rtype.funct3 = (f < 5) ? 3'(f) : 3'd6;
        end
        default: begin
          w.itype.opcode    = `EXEC_OPC_IMM;
          w.itype.funct3    = 3'd1;
          w.itype.imm[11:5] = 7'(urand(127) + 1);
        end
      endcase
      issue(w, op_nop, 1'b0);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic compare_wb_addr(input logic [`EXEC_RAW-1:0] got,
                                 input logic [`EXEC_RAW-1:0] exp);
    if (got !== exp) begin
      addr_errors++;
      $display("Error at %0t ns: wb_addr is x%0d, expected x%0d", $time, got, exp);
    end
  endtask

  task automatic compare_wb_data(input logic [`EXEC_XLEN-1:0] got,
                                 input logic [`EXEC_XLEN-1:0] exp);
    if (got !== exp) begin
      data_errors++;
      $display("Error at %0t ns: wb_data is %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic compare_busy(input logic got, input logic exp);
    if (got !== exp) begin
      ctrl_errors++;
      $display("Error at %0t ns: busy is %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic compare_latency(input int got, input int exp);
    if (got != exp) begin
      ctrl_errors++;
      $display("Error at %0t ns: writeback latency is %0d cycles, expected %0d",
               $time, got, exp);
    end
  endtask

  task automatic check_busy();
    bit div_done;
    div_done = wb_valid && exp_div.size() != 0 && exp_div[0];
    if (!div_open || cycle == div_cycle) begin
      compare_busy(busy, 1'b0);
    end else if (cycle == div_cycle + 1) begin
      // A divide raises busy in the cycle after its strobe
      compare_busy(busy, 1'b1);
    end else if (div_writes && div_done) begin
      compare_busy(busy, 1'b0);
      div_open = 1'b0;
    end else if (!div_writes && !busy) begin
      div_open = 1'b0;
    end else begin
      compare_busy(busy, 1'b1);
    end
  endtask

  task automatic check_writeback();
    if (exp_addr.size() == 0) begin
      ctrl_errors++;
      $display("Writeback to x%0d at %0t ns with no instruction outstanding", wb_addr, $time);
    end else begin
      compare_wb_addr(wb_addr, exp_addr[0]);
      compare_wb_data(wb_data, exp_data[0]);
      if (!exp_div[0]) begin
        compare_latency(cycle - exp_cycle[0], 2);
      end else if (cycle - exp_cycle[0] > `EXEC_DIV_STEPS + 10) begin
        ctrl_errors++;
        $display("Divide result at %0t ns took %0d cycles", $time, cycle - exp_cycle[0]);
      end
      void'(exp_addr.pop_front());
      void'(exp_data.pop_front());
      void'(exp_cycle.pop_front());
      void'(exp_div.pop_front());
    end
  endtask

  // Outputs are settled by the falling edge
  always @(negedge clk) begin
    // Nothing is clocked before the first rising edge
    if (cycle != 0) begin
      if (!rst) begin
        if (wb_valid !== 1'b0 || busy !== 1'b0) begin
          ctrl_errors++;
          $display("wb_valid or busy was high during reset at %0t ns", $time);
        end
      end else begin
        if (in_valid && busy) begin
          ctrl_errors++;
          $display("An instruction was strobed while busy at %0t ns", $time);
        end
        check_busy();
        if (wb_valid) check_writeback();
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed     = 93;
    rst      = 1'b0;
    in_valid = 1'b0;
    instr    = '0;
    for (int k = 0; k < `EXEC_NREGS; k++) begin
      model_regs[k] = '0;
    end
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b1;

    // Each register is read before anything writes it
    for (int r = 1; r < `EXEC_NREGS; r++) begin
      issue(make_r(op_add, 5'(r), 5'(r), 5'd0), op_add, 1'b0);
    end

    issue(make_i(op_add, 5'd1, 5'd0, 12'h7ff), op_add, 1'b1);
    issue(make_i(op_add, 5'd2, 5'd0, 12'h800), op_add, 1'b1);
    issue(make_r(op_divu, 5'd3, 5'd1, 5'd0), op_divu, 1'b0);
    issue(make_r(op_remu, 5'd4, 5'd2, 5'd0), op_remu, 1'b0);
    issue(make_r(op_divu, 5'd5, 5'd2, 5'd1), op_divu, 1'b0);
    issue(make_r(op_add, 5'd0, 5'd1, 5'd2), op_add, 1'b0);
    issue(make_r(op_or, 5'd6, 5'd0, 5'd0), op_or, 1'b0);

    repeat (N_RAND) begin
      if (urand(4) == 0) idle(urand(3));
      random_instr();
    end

    while (exp_addr.size() != 0 || busy) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);

    $display("Summary: %0d wb_addr errors, %0d wb_data errors, %0d control errors",
             addr_errors, data_errors, ctrl_errors);
    if (addr_errors + data_errors + ctrl_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(N_INSTR * (`EXEC_DIV_STEPS + 10) * PERIOD);
    $display("Timeout: the run did not finish within %0d cycles",
             N_INSTR * (`EXEC_DIV_STEPS + 10));
    $display("Regression failed");
    $finish;
  end

endmodule
